// File: prog.hex
// One 32-bit RV32I instruction word per line, from byte address 0 upward
// The all-zero word at the end halts the core
12300093
ff800113
04000513
002081b3
40208233
401152b3
00415313
40215393
00112433
00513493
fe352c23
03802583
0065e633
00508013
004046b3
00452703
002097b3
00f02023
00000000

// File: compile.f
+incdir+tests
src/rv_pkg.sv
src/rv_exec_if.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_lsu.sv
src/rv_core.sv
tests/rv_core_props.sv
tests/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/rv_exec_if.sv
  - src/rv_regfile.sv
  - src/rv_alu.sv
  - src/rv_lsu.sv
  - src/rv_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/rv_core_props.sv
      - tests/tb_rv_core.sv

// File: tests/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

    logic [31:0] prog [0:rv_pkg::IMEM_DEPTH-1];
    logic [31:0] xreg [0:31];                   // Architectural registers
    logic [31:0] dmem [0:63];                   // Model view of data memory
    logic [31:0] mpc;
    int          n_prog;                        // Words before the halt word
    logic [31:0] lfsr = 32'h38ab0a02;

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic int rand_bits(int n);
        int val;
        val = 0;
        for (int k = 0; k < n; k++) begin
            val  = (val << 1) | lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic [31:0] fill_word(int idx);
        logic [31:0] addr;
        addr = idx * 4;
        return (addr + 32'h1) * 32'h9e3779b9;   // Every address bit matters
    endfunction

    function automatic logic [31:0] imm_i(rv_pkg::rv_instr_u ins);
        return {{20{ins.i.imm[11]}}, ins.i.imm};
    endfunction

    function automatic logic [31:0] imm_s(rv_pkg::rv_instr_u ins);
        return {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
    endfunction

    function automatic logic [31:0] alu_ref(rv_pkg::rv_instr_u ins);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        is_reg;
        is_reg = (ins.r.opcode == rv_pkg::OPC_OP);
        a      = xreg[ins.r.rs1];
        b      = is_reg ? xreg[ins.r.rs2] : imm_i(ins);
        sh     = b[4:0];
        case (ins.r.funct3)
            rv_pkg::F3_ADD_SUB: return (is_reg && ins.r.funct7[5]) ? a - b : a + b;
            rv_pkg::F3_SLL:     return a << sh;
            rv_pkg::F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_pkg::F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            rv_pkg::F3_XOR:     return a ^ b;
            rv_pkg::F3_SR: begin
                // Fill the vacated top bits with the sign for the arithmetic form
                return (a >> sh) | ((ins.r.funct7[5] && a[31]) ? ~(32'hffffffff >> sh) : 32'h0);
            end
            rv_pkg::F3_OR:      return a | b;
            default:            return a & b;
        endcase
    endfunction

    initial begin
        $readmemh("prog.hex", prog);
        n_prog = 0;
        while (n_prog < rv_pkg::IMEM_DEPTH && prog[n_prog] !== 32'h0) begin
            n_prog++;
        end
        mpc = 32'h0;
        for (int i = 0; i < 32; i++) begin
            xreg[i] = 32'h0;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fill_word(i);
        end
    end

    // AXI write request against the store the model is about to retire
    task automatic check_store_request();
        rv_pkg::rv_instr_u ins;
        ins = prog[mpc[7:2]];
        check_value("awaddr", awaddr, xreg[ins.s.rs1] + imm_s(ins));
        check_value("wdata", wdata, xreg[ins.s.rs2]);
        check_value("wstrb", wstrb, 32'hf);
    endtask

    task automatic step_model();
        rv_pkg::rv_instr_u ins;
        logic [31:0]       exp;
        logic [31:0]       ea;
        ins = prog[mpc[7:2]];
        check_value("retire_pc", retire_pc, mpc);
        if (ins.s.opcode == rv_pkg::OPC_STORE) begin
            ea  = xreg[ins.s.rs1] + imm_s(ins);
            exp = xreg[ins.s.rs2];
            dmem[ea[7:2]] = exp;
            check_value("retire_rd", retire_rd, 32'h0);
        end else begin
            if (ins.i.opcode == rv_pkg::OPC_LOAD) begin
                ea  = xreg[ins.i.rs1] + imm_i(ins);
                exp = dmem[ea[7:2]];
            end else begin
                exp = alu_ref(ins);
            end
            check_value("retire_rd", retire_rd, ins.i.rd);
            if (ins.i.rd != 5'd0) begin
                xreg[ins.i.rd] = exp;    // x0 stays zero
            end
        end
        check_value("retire_data", retire_data, exp);
        mpc = mpc + 32'd4;
    endtask

`endif

// File: tests/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

    logic                      CLK;
    logic                      RST;
    logic [rv_pkg::XLEN-1:0]   awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [rv_pkg::XLEN-1:0]   wdata;
    logic [rv_pkg::XLEN/8-1:0] wstrb;
    logic                      wvalid;
    logic                      wready;
    logic                      bvalid;
    logic                      bready;
    logic [rv_pkg::XLEN-1:0]   araddr;
    logic                      arvalid;
    logic                      arready;
    logic [rv_pkg::XLEN-1:0]   rdata;
    logic                      rvalid;
    logic                      rready;
    logic                      retire_valid;
    logic [rv_pkg::XLEN-1:0]   retire_pc;
    logic [rv_pkg::REG_AW-1:0] retire_rd;
    logic [rv_pkg::XLEN-1:0]   retire_data;
    logic                      halted;

    logic [31:0] slave_mem [0:63];
    int          errors  = 0;
    int          retires = 0;
    time         last_retire_t = 0;    // Edge at which the latest retire was seen

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
            else begin
                errors++;
                $display("ERR %s: got %h, expected %h", name, got, exp);
            end
    endtask

    `include "rv_ref_model.svh"

    rv_core u_dut (.*);

    bind rv_core rv_core_props u_props (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    initial begin
        RST     = 1'b1;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        arready = 1'b0;
        rdata   = '0;
        rvalid  = 1'b0;
        for (int i = 0; i < 64; i++) begin
            slave_mem[i] = fill_word(i);
        end
        repeat (8) @(posedge CLK);
        RST <= 1'b0;
        wait (halted === 1'b1);
        // The zero word shows up as the last instruction retires
        assert ($time == last_retire_t)
            else begin
                errors++;
                $display("halted did not rise in the cycle right after the last retire");
            end
        @(posedge CLK);
        check_value("retire count", retires, n_prog);
        $display("Errors: %0d model checks, %0d protocol checks",
                 errors, u_dut.u_props.fail_cnt);
        if (errors == 0 && u_dut.u_props.fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    always @(posedge CLK) begin
        if (!RST && retire_valid === 1'b1) begin
            step_model();
            retires++;
            last_retire_t = $time;
        end
    end

    // Read channel of the slave memory
    initial begin : read_slave
        rv_pkg::rv_instr_u ins;
        forever begin
            @(posedge CLK);
            if (!RST && arvalid === 1'b1) begin
                ins = prog[mpc[7:2]];
                check_value("araddr", araddr, xreg[ins.i.rs1] + imm_i(ins));
                repeat (rand_bits(2)) @(posedge CLK);
                arready <= 1'b1;
                @(posedge CLK);    // Address handshake
                arready <= 1'b0;
                rdata   <= slave_mem[araddr[7:2]];
                rvalid  <= 1'b1;
                @(posedge CLK);
                while (!rready) @(posedge CLK);
                rvalid <= 1'b0;
            end
        end
    end

    // Write channels with independently delayed readies
    initial begin : write_slave
        int aw_delay;
        int w_delay;
        forever begin
            @(posedge CLK);
            if (!RST && awvalid === 1'b1) begin
                check_store_request();
                aw_delay = rand_bits(2);
                w_delay  = rand_bits(2);
                fork
                    begin
                        repeat (aw_delay) @(posedge CLK);
                        awready <= 1'b1;
                        @(posedge CLK);
                        awready <= 1'b0;
                    end
                    begin
                        repeat (w_delay) @(posedge CLK);
                        wready <= 1'b1;
                        @(posedge CLK);
                        wready <= 1'b0;
                    end
                join
                slave_mem[awaddr[7:2]] = wdata;
                bvalid <= 1'b1;
                @(posedge CLK);
                while (!bready) @(posedge CLK);
                bvalid <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        #1;
        #((n_prog + 8) * 8 * 40);    // Reset plus a generous budget per instruction
        $display("Watchdog expired: halted never rose within the program's time budget");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/rv_core_props.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_props (
    input logic                    CLK,
    input logic                    RST,
    input logic [rv_pkg::XLEN-1:0] araddr,
    input logic                    arvalid,
    input logic                    arready,
    input logic [rv_pkg::XLEN-1:0] awaddr,
    input logic                    awvalid,
    input logic                    awready,
    input logic [rv_pkg::XLEN-1:0] wdata,
    input logic                    wvalid,
    input logic                    wready,
    input logic                    retire_valid,
    input logic                    halted,
    input logic                    busy
);

    int fail_cnt = 0;

    assert property (@(posedge CLK) RST |=>
                     !(arvalid || awvalid || wvalid || retire_valid || halted))
        else begin
            fail_cnt++;
            $error("A valid or halted was high in the cycle after reset");
        end

    assert property (@(posedge CLK) disable iff (RST)
                     arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            fail_cnt++;
            $error("arvalid dropped or araddr changed before arready");
        end

    assert property (@(posedge CLK) disable iff (RST)
                     awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            fail_cnt++;
            $error("awvalid dropped or awaddr changed before awready");
        end

    assert property (@(posedge CLK) disable iff (RST)
                     wvalid && !wready |=> wvalid && $stable(wdata))
        else begin
            fail_cnt++;
            $error("wvalid dropped or wdata changed before wready");
        end

    // No retire while a load or store is in flight
    assert property (@(posedge CLK) disable iff (RST) busy |-> !retire_valid)
        else begin
            fail_cnt++;
            $error("retire_valid high while a memory access was in flight");
        end

    assert property (@(posedge CLK) disable iff (RST) halted |-> !retire_valid ##1 halted)
        else begin
            fail_cnt++;
            $error("halted cleared or an instruction retired after halt");
        end

endmodule

`default_nettype wire

// File: src/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core (
    input  logic                         CLK,
    input  logic                         RST,
    // AXI4-Lite data memory master
    output logic [rv_pkg::XLEN-1:0]      awaddr,
    output logic                         awvalid,
    input  logic                         awready,
    output logic [rv_pkg::XLEN-1:0]      wdata,
    output logic [rv_pkg::XLEN/8-1:0]    wstrb,
    output logic                         wvalid,
    input  logic                         wready,
    input  logic                         bvalid,
    output logic                         bready,
    output logic [rv_pkg::XLEN-1:0]      araddr,
    output logic                         arvalid,
    input  logic                         arready,
    input  logic [rv_pkg::XLEN-1:0]      rdata,
    input  logic                         rvalid,
    output logic                         rready,
    // Retire report
    output logic                         retire_valid,
    output logic [rv_pkg::XLEN-1:0]      retire_pc,
    output logic [rv_pkg::REG_AW-1:0]    retire_rd,
    output logic [rv_pkg::XLEN-1:0]      retire_data,
    output logic                         halted
);

    logic [rv_pkg::XLEN-1:0] imem [0:rv_pkg::IMEM_DEPTH-1];
    logic [rv_pkg::XLEN-1:0] pc;
    rv_pkg::rv_instr_u       instr;
    logic                    is_op;
    logic                    is_op_imm;
    logic                    is_load;
    logic                    is_store;
    logic                    supported;
    logic                    busy;          // Waiting on the LSU
    logic                    alu_issue;
    logic                    lsu_start;
    logic                    lsu_done;
    logic [rv_pkg::XLEN-1:0] load_data;
    logic [rv_pkg::XLEN-1:0] alu_result;
    logic [rv_pkg::XLEN-1:0] rdata_a;
    logic [rv_pkg::XLEN-1:0] rdata_b;
    logic                    wb_we;
    logic [rv_pkg::XLEN-1:0] wb_data;

    rv_exec_if ex ();

    initial $readmemh("prog.hex", imem);

    assign instr = imem[pc[rv_pkg::IMEM_AW+1:2]];

    // Decode
    assign is_op     = (instr.r.opcode == rv_pkg::OPC_OP);
    assign is_op_imm = (instr.i.opcode == rv_pkg::OPC_OP_IMM);
    assign is_load   = (instr.i.opcode == rv_pkg::OPC_LOAD) && (instr.i.funct3 == rv_pkg::F3_LW_SW);
    assign is_store  = (instr.s.opcode == rv_pkg::OPC_STORE) && (instr.s.funct3 == rv_pkg::F3_LW_SW);
    assign supported = is_op || is_op_imm || is_load || is_store;

    assign ex.valid    = supported && !halted;
    assign ex.funct3   = instr.r.funct3;
    assign ex.alt      = instr.r.funct7[5];
    assign ex.use_imm  = !is_op;
    assign ex.is_load  = is_load;
    assign ex.is_store = is_store;
    assign ex.op_a     = rdata_a;
    assign ex.op_b     = rdata_b;
    assign ex.imm      = is_store ? {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo}
                                  : {{20{instr.i.imm[11]}}, instr.i.imm};

    // Issue and writeback
    assign alu_issue = (is_op || is_op_imm) && !busy && !halted;
    assign lsu_start = (is_load || is_store) && !busy && !halted;
    assign wb_we     = alu_issue || (lsu_done && is_load);
    assign wb_data   = lsu_done ? load_data : alu_result;

    rv_regfile u_regfile (
        .CLK     (CLK),
        .raddr_a (instr.r.rs1),
        .raddr_b (instr.r.rs2),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (wb_we),
        .waddr   (instr.r.rd),
        .wdata   (wb_data)
    );

    rv_alu u_alu (
        .ex     (ex.alu),
        .result (alu_result)
    );

    rv_lsu u_lsu (
        .CLK (CLK), .RST (RST), .ex (ex.lsu),
        .start (lsu_start), .done (lsu_done), .load_data (load_data),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rvalid (rvalid), .rready (rready)
    );

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc           <= '0;
            busy         <= 1'b0;
            halted       <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= alu_issue || lsu_done;
            if (lsu_start) busy <= 1'b1;    // PC held until done
            if (alu_issue || lsu_done) begin
                pc   <= pc + 32'd4;
                busy <= 1'b0;
            end
            if (!supported && !busy && !halted) halted <= 1'b1;    // Sticky until reset
        end
    end

    // Retire payload, a store reports its data with rd zero
    always_ff @(posedge CLK) begin
        if (alu_issue || lsu_done) begin
            retire_pc   <= pc;
            retire_rd   <= is_store ? '0 : instr.r.rd;
            retire_data <= is_store ? rdata_b : wb_data;
        end
    end

endmodule

`default_nettype wire

// File: src/rv_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_lsu (
    input  logic                         CLK,
    input  logic                         RST,
    rv_exec_if.lsu                       ex,
    input  logic                         start,
    output logic                         done,
    output logic [rv_pkg::XLEN-1:0]      load_data,
    // AXI4-Lite master
    output logic [rv_pkg::XLEN-1:0]      awaddr,
    output logic                         awvalid,
    input  logic                         awready,
    output logic [rv_pkg::XLEN-1:0]      wdata,
    output logic [rv_pkg::XLEN/8-1:0]    wstrb,
    output logic                         wvalid,
    input  logic                         wready,
    input  logic                         bvalid,
    output logic                         bready,
    output logic [rv_pkg::XLEN-1:0]      araddr,
    output logic                         arvalid,
    input  logic                         arready,
    input  logic [rv_pkg::XLEN-1:0]      rdata,
    input  logic                         rvalid,
    output logic                         rready
);

    logic [2:0]              state;
    logic [rv_pkg::XLEN-1:0] addr_q;      // Effective address
    logic [rv_pkg::XLEN-1:0] sdata_q;     // Store data

    always_ff @(posedge CLK) begin
        if (RST) begin
            state   <= rv_pkg::LSU_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                rv_pkg::LSU_IDLE: begin
                    if (start && ex.valid && ex.is_store) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= rv_pkg::LSU_WRITE;
                    end else if (start && ex.valid && ex.is_load) begin
                        arvalid <= 1'b1;
                        state   <= rv_pkg::LSU_ADDR;
                    end
                end
                rv_pkg::LSU_ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        state   <= rv_pkg::LSU_READ;
                    end
                end
                rv_pkg::LSU_READ: begin
                    if (rvalid) begin
                        done  <= 1'b1;
                        state <= rv_pkg::LSU_IDLE;
                    end
                end
                rv_pkg::LSU_WRITE: begin
                    if (awready) awvalid <= 1'b0;    // Each channel completes on its own
                    if (wready) wvalid <= 1'b0;
                    if ((awready || !awvalid) && (wready || !wvalid)) begin
                        state <= rv_pkg::LSU_RESP;
                    end
                end
                default: begin    // LSU_RESP
                    if (bvalid) begin
                        done  <= 1'b1;
                        state <= rv_pkg::LSU_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == rv_pkg::LSU_IDLE && start) begin
            addr_q  <= ex.op_a + ex.imm;
            sdata_q <= ex.op_b;
        end
        if (state == rv_pkg::LSU_READ && rvalid) begin
            load_data <= rdata;
        end
    end

    assign awaddr = addr_q;
    assign araddr = addr_q;
    assign wdata  = sdata_q;
    assign wstrb  = '1;    // Full words only
    assign bready = (state == rv_pkg::LSU_RESP);
    assign rready = (state == rv_pkg::LSU_READ);

endmodule

`default_nettype wire

// File: src/rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
    rv_exec_if.alu                  ex,
    output logic [rv_pkg::XLEN-1:0] result
);

    logic [rv_pkg::XLEN-1:0] opnd_b;
    logic [4:0]              shamt;

    assign opnd_b = ex.use_imm ? ex.imm : ex.op_b;
    assign shamt  = opnd_b[4:0];    // Low 5 bits only

    always_comb begin
        case (ex.funct3)
            rv_pkg::F3_ADD_SUB: begin
                // addi has no subtract form, bit 30 belongs to the immediate there
                if (ex.alt && !ex.use_imm) begin
                    result = ex.op_a - opnd_b;
                end else begin
                    result = ex.op_a + opnd_b;
                end
            end
            rv_pkg::F3_SLL:  result = ex.op_a << shamt;
            rv_pkg::F3_SLT:  result = {31'd0, $signed(ex.op_a) < $signed(opnd_b)};
            rv_pkg::F3_SLTU: result = {31'd0, ex.op_a < opnd_b};
            rv_pkg::F3_XOR:  result = ex.op_a ^ opnd_b;
            rv_pkg::F3_SR: begin
                if (ex.alt) begin
                    result = $unsigned($signed(ex.op_a) >>> shamt);    // Arithmetic
                end else begin
                    result = ex.op_a >> shamt;
                end
            end
            rv_pkg::F3_OR:   result = ex.op_a | opnd_b;
            default:         result = ex.op_a & opnd_b;    // F3_AND
        endcase
    end

endmodule

`default_nettype wire

// File: src/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
    input  logic                      CLK,
    input  logic [rv_pkg::REG_AW-1:0] raddr_a,
    input  logic [rv_pkg::REG_AW-1:0] raddr_b,
    output logic [rv_pkg::XLEN-1:0]   rdata_a,
    output logic [rv_pkg::XLEN-1:0]   rdata_b,
    input  logic                      we,
    input  logic [rv_pkg::REG_AW-1:0] waddr,
    input  logic [rv_pkg::XLEN-1:0]   wdata
);

    logic [rv_pkg::XLEN-1:0] regs [0:(1 << rv_pkg::REG_AW)-1];

    // Entry 0 is never written, so it is masked on read
    always_ff @(posedge CLK) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];    // x0 reads zero
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

// File: src/rv_exec_if.sv
`timescale 1ns/10ps
`default_nettype none

interface rv_exec_if;

    logic                     valid;
    logic [2:0]               funct3;
    logic                     alt;         // Instruction bit 30
    logic                     use_imm;
    logic                     is_load;
    logic                     is_store;
    logic [rv_pkg::XLEN-1:0]  op_a;        // rs1 value
    logic [rv_pkg::XLEN-1:0]  op_b;        // rs2 value
    logic [rv_pkg::XLEN-1:0]  imm;         // Sign-extended I or S immediate

    modport core (output valid, funct3, alt, use_imm, is_load, is_store, op_a, op_b, imm);
    modport alu  (input funct3, alt, use_imm, op_a, op_b, imm);
    modport lsu  (input valid, is_load, is_store, op_a, op_b, imm);

endinterface

`default_nettype wire

// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int IMEM_DEPTH = 64;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);

    // Supported major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;    // srl and sra, split by bit 30
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW_SW   = 3'b010;    // Word access only

    // LSU state codes
    localparam logic [2:0] LSU_IDLE  = 3'd0;
    localparam logic [2:0] LSU_ADDR  = 3'd1;
    localparam logic [2:0] LSU_WRITE = 3'd2;
    localparam logic [2:0] LSU_RESP  = 3'd3;
    localparam logic [2:0] LSU_READ  = 3'd4;

    // One instruction word, viewed through the format the opcode selects
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
    } rv_instr_u;

endpackage

`default_nettype wire
